//--- dv/core_tb.sv
`include "core_cfg.svh"

module core_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    localparam int IMEM_MASK    = (1 << `CORE_IMEM_AW) - 1;

    // One expected register write on the commit trace
    typedef struct packed {
        logic [`CORE_RF_AW-1:0]  addr;
        logic [`CORE_DATA_W-1:0] data;
    } commit_t;

    logic                       clk;
    logic                       n_reset;
    logic [`CORE_NET_ID_W-1:0]  net_id_i;
    net_op_e                    net_op_i;
    logic [`CORE_IMEM_AW-1:0]   net_addr_i;
    logic [`CORE_DATA_W-1:0]    net_data_i;
    core_state_e                state_o;
    logic                       exception_o;
    logic                       trace_wen_o;
    logic [`CORE_RF_AW-1:0]     trace_addr_o;
    logic [`CORE_DATA_W-1:0]    trace_data_o;

    // Software copies of register file and instruction memory
    logic [`CORE_DATA_W-1:0]    model_rf [0:(1<<`CORE_RF_AW)-1];
    instr_t                     model_imem [0:(1<<`CORE_IMEM_AW)-1];
    // Program table being built, and commits still to come
    instr_t                     prog [$];
    commit_t                    exp_q [$];
    commit_t                    exp_entry;

    integer                     seed;
    int                         cycle_count;
    int                         cycle_limit;

    core uut (
        .clk            (clk),
        .n_reset        (n_reset),
        .net_id_i       (net_id_i),
        .net_op_i       (net_op_i),
        .net_addr_i     (net_addr_i),
        .net_data_i     (net_data_i),
        .state_o        (state_o),
        .exception_o    (exception_o),
        .trace_wen_o    (trace_wen_o),
        .trace_addr_o   (trace_addr_o),
        .trace_data_o   (trace_data_o)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at first failure");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("ERROR at %0t: %s", $time, msg));
    endtask

    // Packet stays on the inputs for one cycle
    task automatic send_packet(input logic [`CORE_NET_ID_W-1:0] id, input net_op_e op,
                               input logic [`CORE_IMEM_AW-1:0] addr,
                               input logic [`CORE_DATA_W-1:0] data);
        @(posedge clk);
        net_id_i   <= id;
        net_op_i   <= op;
        net_addr_i <= addr;
        net_data_i <= data;
    endtask

    task automatic idle_net(input int n);
        repeat (n)
        begin
            @(posedge clk);
            net_id_i <= '0;
            net_op_i <= NET_NONE;
        end
    endtask

    function automatic instr_t make_instr(input opcode_e op, input int rd, input int rs_imm);
        instr_t w;
        w.op     = op;
        w.rd     = rd[`CORE_RF_AW-1:0];
        w.rs_imm = rs_imm[`CORE_RF_AW-1:0];
        return w;
    endfunction

    // Every write reaches the trace, even one to r0
    task automatic model_write(input logic [`CORE_RF_AW-1:0] rd,
                               input logic [`CORE_DATA_W-1:0] v);
        commit_t c;
        c.addr = rd;
        c.data = v;
        exp_q.push_back(c);
        if (rd != 0)
            model_rf[rd] = v;
    endtask

    task automatic write_reg(input int r, input logic [`CORE_DATA_W-1:0] v);
        send_packet(`CORE_NET_ID, NET_REG, r[`CORE_IMEM_AW-1:0], v);
        model_write(r[`CORE_RF_AW-1:0], v);
    endtask

    // Table goes out as INSTR packets and into the memory copy
    task automatic load_program(input int base);
        foreach (prog[i])
        begin
            send_packet(`CORE_NET_ID, NET_INSTR, 8'((base + i) & IMEM_MASK), {16'h0, prog[i]});
            model_imem[(base + i) & IMEM_MASK] = prog[i];
        end
        cycle_limit += prog.size();
        idle_net(1);
    endtask

    // In-order execution until DONE, one instruction per step
    task automatic run_model(input int start);
        int                         pc;
        int                         pc_next;
        int                         steps;
        int                         offset;
        bit                         running;
        instr_t                     w;
        logic [`CORE_DATA_W-1:0]    a;
        logic [`CORE_DATA_W-1:0]    b;
        pc      = start;
        steps   = 0;
        running = 1'b1;
        while (running && steps < 256)
        begin
            w       = model_imem[pc];
            a       = model_rf[w.rd];
            b       = model_rf[w.rs_imm];
            // Branch offset is a signed 5-bit field
            offset  = w.rs_imm[`CORE_RF_AW-1] ? int'(w.rs_imm) - 32 : int'(w.rs_imm);
            pc_next = (pc + 1) & IMEM_MASK;
            steps++;
            case (w.op)
                ADD:   model_write(w.rd, a + b);
                SUB:   model_write(w.rd, a - b);
                AND:   model_write(w.rd, a & b);
                OR:    model_write(w.rd, a | b);
                XOR:   model_write(w.rd, a ^ b);
                MOV:   model_write(w.rd, b);
                BEQZ:
                begin
                    if (a == 0)
                        pc_next = (pc + offset) & IMEM_MASK;
                end
                BNEQZ:
                begin
                    if (a != 0)
                        pc_next = (pc + offset) & IMEM_MASK;
                end
                JALR:
                begin
                    // Link is the address after the jump
                    model_write(w.rd, 32'((pc + 1) & IMEM_MASK));
                    pc_next = int'(b[`CORE_IMEM_AW-1:0]);
                end
                DONE:  running = 1'b0;
                default: ;
            endcase
            pc = pc_next;
        end
    endtask

    // Start at base, wait for DONE to bring the core back to IDLE
    task automatic start_and_wait(input int base);
        send_packet(`CORE_NET_ID, NET_PC, 8'(base), '0);
        idle_net(1);
        do
            @(posedge clk);
        while (state_o != IDLE);
        assert (exp_q.size() == 0)
            else report_error($sformatf("%0d expected commits missing", exp_q.size()));
    endtask

    net_reg_traced: assert property (@(posedge clk) disable iff (!n_reset)
        (net_id_i == `CORE_NET_ID && net_op_i == NET_REG)
        |-> (trace_wen_o && trace_addr_o == net_addr_i[`CORE_RF_AW-1:0]
             && trace_data_o == net_data_i))
        else report_error("network register write not on the trace in the same cycle");

    // Pipeline is frozen outside RUN, so foreign packets leave the trace quiet
    foreign_quiet: assert property (@(posedge clk) disable iff (!n_reset)
        (net_id_i != `CORE_NET_ID && state_o != RUN) |-> !trace_wen_o)
        else report_error("trace write from a packet with a foreign ID");

    pc_starts_core: assert property (@(posedge clk) disable iff (!n_reset)
        (net_id_i == `CORE_NET_ID && net_op_i == NET_PC && state_o == IDLE)
        |=> (state_o == RUN))
        else report_error("PC packet in IDLE did not start the core");

    pc_in_run_errs: assert property (@(posedge clk) disable iff (!n_reset)
        (net_id_i == `CORE_NET_ID && net_op_i == NET_PC && state_o == RUN)
        |=> (state_o == ERR && exception_o))
        else report_error("PC packet in RUN did not raise the exception");

    // ERR and the flag hold until reset
    err_sticky: assert property (@(posedge clk) disable iff (!n_reset)
        (exception_o || state_o == ERR) |=> (exception_o && state_o == ERR))
        else report_error("exception or ERR state dropped");

    // Every trace write must match the head of the expected queue
    always @(posedge clk)
    begin
        if (n_reset && trace_wen_o)
        begin
            assert (exp_q.size() != 0)
                else report_error($sformatf("unexpected write r%0d = %h",
                                            trace_addr_o, trace_data_o));
            exp_entry = exp_q.pop_front();
            assert (trace_addr_o == exp_entry.addr && trace_data_o == exp_entry.data)
                else report_error($sformatf("trace r%0d = %h, expected r%0d = %h",
                                            trace_addr_o, trace_data_o,
                                            exp_entry.addr, exp_entry.data));
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
            stop_run($sformatf("Timeout, the tests did not finish in %0d cycles", cycle_limit));
    end

    initial
    begin
        seed        = 32'hd3f139d7;
        cycle_count = 0;
        cycle_limit = RESET_CYCLES + `CORE_TIMEOUT_MARGIN;
        clk         = 1'b0;
        n_reset     = 1'b0;
        net_id_i    = '0;
        net_op_i    = NET_NONE;
        net_addr_i  = '0;
        net_data_i  = '0;
        foreach (model_rf[i])
            model_rf[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        n_reset <= 1'b1;

        repeat (3)
        begin
            @(posedge clk);
            assert (state_o == IDLE && !exception_o && !trace_wen_o)
                else report_error("core not idle and quiet after reset");
        end

        // Random register values, also the operands of the programs below
        for (int r = 1; r <= 13; r++)
            write_reg(r, $random(seed));
        send_packet(`CORE_NET_ID ^ 10'h155, NET_REG, 8'd3, $random(seed));
        send_packet(`CORE_NET_ID ^ 10'h2aa, NET_PC, 8'h10, '0);
        idle_net(2);
        assert (state_o == IDLE)
            else report_error("foreign PC packet started the core");

        // Dependent chain, each result feeds the next instruction
        prog.delete();
        prog.push_back(make_instr(ADD, 3, 1));
        prog.push_back(make_instr(SUB, 4, 3));
        prog.push_back(make_instr(XOR, 3, 4));
        prog.push_back(make_instr(MOV, 5, 3));
        prog.push_back(make_instr(AND, 5, 2));
        prog.push_back(make_instr(OR, 6, 5));
        prog.push_back(make_instr(DONE, 0, 0));
        load_program(8'h10);
        run_model(8'h10);
        start_and_wait(8'h10);

        // Branches both ways, JALR to 0x4c, backward branch onto DONE
        write_reg(11, 32'h4c);
        prog.delete();
        prog.push_back(make_instr(XOR, 8, 8));
        prog.push_back(make_instr(BEQZ, 8, 3));
        prog.push_back(make_instr(ADD, 1, 1));
        prog.push_back(make_instr(ADD, 2, 2));
        prog.push_back(make_instr(BNEQZ, 8, 2));
        prog.push_back(make_instr(MOV, 9, 1));
        prog.push_back(make_instr(BNEQZ, 9, 2));
        prog.push_back(make_instr(SUB, 9, 9));
        prog.push_back(make_instr(JALR, 12, 11));
        prog.push_back(make_instr(ADD, 3, 3));
        prog.push_back(make_instr(ADD, 4, 4));
        prog.push_back(make_instr(DONE, 0, 0));
        prog.push_back(make_instr(OR, 13, 12));
        prog.push_back(make_instr(BEQZ, 0, -2));
        prog.push_back(make_instr(ADD, 14, 14));
        load_program(8'h40);
        run_model(8'h40);
        start_and_wait(8'h40);

        // Endless loop keeps the core in RUN for the stray PC packet
        prog.delete();
        prog.push_back(make_instr(BEQZ, 0, 0));
        load_program(8'h80);
        send_packet(`CORE_NET_ID, NET_PC, 8'h80, '0);
        idle_net(4);
        assert (state_o == RUN)
            else report_error("loop program did not start");
        send_packet(`CORE_NET_ID, NET_PC, 8'h10, '0);
        idle_net(1);
        repeat (10)
        begin
            @(posedge clk);
            assert (state_o == ERR && exception_o)
                else report_error("core not held in ERR with the exception raised");
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Instruction memory address width, also the program counter width
`define CORE_IMEM_AW 8

// Register file address width
`define CORE_RF_AW 5

// Datapath width
`define CORE_DATA_W 32

// Node ID of this core on the network
`define CORE_NET_ID_W 10
`define CORE_NET_ID 10'd1

// Extra cycles allowed beyond program length before a run is declared hung
`define CORE_TIMEOUT_MARGIN 200

`endif

//--- logic/alu.sv
`include "core_cfg.svh"

module alu
    import core_pkg::*;
(
    input  instr_t                      op_i,
    input  logic [`CORE_DATA_W-1:0]     rd_i,
    input  logic [`CORE_DATA_W-1:0]     rs_i,
    input  logic [`CORE_IMEM_AW-1:0]    pc_i,
    output logic [`CORE_DATA_W-1:0]     result_o,
    output logic                        branch_taken_o
);

    logic [`CORE_IMEM_AW-1:0] br_target;

    // PC plus sign-extended offset
    assign br_target = pc_i + {{(`CORE_IMEM_AW-`CORE_RF_AW){op_i.rs_imm[`CORE_RF_AW-1]}},
                               op_i.rs_imm};

    always_comb
    begin
        result_o       = '0;
        branch_taken_o = 1'b0;
        case (op_i.op)
            ADD: result_o = rd_i + rs_i;
            SUB: result_o = rd_i - rs_i;
            AND: result_o = rd_i & rs_i;
            OR:  result_o = rd_i | rs_i;
            XOR: result_o = rd_i ^ rs_i;
            MOV: result_o = rs_i;
            // Branches put their target on the result bus
            BEQZ:
            begin
                result_o       = {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, br_target};
                branch_taken_o = (rd_i == '0);
            end
            BNEQZ:
            begin
                result_o       = {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, br_target};
                branch_taken_o = (rd_i != '0);
            end
            // Jump target comes from rs
            JALR:
            begin
                result_o       = rs_i;
                branch_taken_o = 1'b1;
            end
            default: result_o = '0;
        endcase
    end

endmodule

//--- logic/core.sv
`include "core_cfg.svh"

module core
    import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic [`CORE_NET_ID_W-1:0]   net_id_i,
    input  net_op_e                     net_op_i,
    input  logic [`CORE_IMEM_AW-1:0]    net_addr_i,
    input  logic [`CORE_DATA_W-1:0]     net_data_i,
    output core_state_e                 state_o,
    output logic                        exception_o,
    output logic                        trace_wen_o,
    output logic [`CORE_RF_AW-1:0]      trace_addr_o,
    output logic [`CORE_DATA_W-1:0]     trace_data_o
);

    logic                       stall;
    logic                       flush;
    logic                       branch_taken;
    logic                       done_commit;
    logic                       op_writes;
    logic                       rf_wen;
    logic [`CORE_RF_AW-1:0]     rf_w_addr;
    logic [`CORE_DATA_W-1:0]    rf_w_data;
    instr_t                     f_instr;
    instr_t                     d_instr;
    logic [`CORE_IMEM_AW-1:0]   f_pc;
    logic [`CORE_IMEM_AW-1:0]   d_pc;
    logic [`CORE_IMEM_AW-1:0]   jalr_link;
    logic [`CORE_DATA_W-1:0]    rs_val;
    logic [`CORE_DATA_W-1:0]    rd_val;
    logic [`CORE_DATA_W-1:0]    rs_fwd;
    logic [`CORE_DATA_W-1:0]    rd_fwd;
    logic [`CORE_DATA_W-1:0]    d_rs_val;
    logic [`CORE_DATA_W-1:0]    d_rd_val;
    logic [`CORE_DATA_W-1:0]    alu_result;

    net_cmd_if cmd ();

    net_ctrl u_net_ctrl (
        .clk            (clk),
        .n_reset        (n_reset),
        .net_id_i       (net_id_i),
        .net_op_i       (net_op_i),
        .net_addr_i     (net_addr_i),
        .net_data_i     (net_data_i),
        .done_commit_i  (done_commit),
        .cmd            (cmd.ctrl),
        .state_o        (state_o),
        .exception_o    (exception_o)
    );

    // Branch and jump targets arrive on the ALU result
    fetch_unit u_fetch (
        .clk        (clk),
        .n_reset    (n_reset),
        .cmd        (cmd.sink),
        .stall_i    (stall),
        .flush_i    (flush),
        .redirect_i (branch_taken),
        .target_i   (alu_result[`CORE_IMEM_AW-1:0]),
        .instr_o    (f_instr),
        .pc_o       (f_pc)
    );

    reg_file u_rf (
        .clk        (clk),
        .rs_addr_i  (f_instr.rs_imm),
        .rd_addr_i  (f_instr.rd),
        .w_addr_i   (rf_w_addr),
        .wen_i      (rf_wen),
        .w_data_i   (rf_w_data),
        .rs_val_o   (rs_val),
        .rd_val_o   (rd_val)
    );

    alu u_alu (
        .op_i           (d_instr),
        .rd_i           (d_rd_val),
        .rs_i           (d_rs_val),
        .pc_i           (d_pc),
        .result_o       (alu_result),
        .branch_taken_o (branch_taken)
    );

    // Only these ops produce a register result
    assign op_writes = d_instr.op inside {ADD, SUB, AND, OR, XOR, MOV, JALR};

    // Network writes own the memory and register ports
    assign stall = (state_o != RUN) || cmd.imem_wr || (cmd.reg_wr && op_writes);

    // Kill younger work on a redirect or when DONE reaches execute
    assign flush       = branch_taken || (d_instr.op == DONE);
    assign done_commit = (d_instr.op == DONE) && !stall;

    // Write-back happens in execute
    assign rf_wen    = cmd.reg_wr || (op_writes && !stall);
    assign rf_w_addr = cmd.reg_wr ? cmd.addr[`CORE_RF_AW-1:0] : d_instr.rd;
    assign jalr_link = d_pc + 1'b1;

    always_comb
    begin
        if (cmd.reg_wr)
            rf_w_data = cmd.data;
        else if (d_instr.op == JALR)
            rf_w_data = {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, jalr_link};
        else
            rf_w_data = alu_result;
    end

    // Bypass the value being written this cycle, except for r0
    assign rs_fwd = (rf_wen && (rf_w_addr != '0) && (rf_w_addr == f_instr.rs_imm))
                  ? rf_w_data : rs_val;
    assign rd_fwd = (rf_wen && (rf_w_addr != '0) && (rf_w_addr == f_instr.rd))
                  ? rf_w_data : rd_val;

    // Decode to execute register
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            d_instr <= '0;
        else if (!stall)
        begin
            if (flush)
                d_instr <= '0;
            else
                d_instr <= f_instr;
        end
    end

    // Operands and PC follow the instruction
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            d_pc     <= f_pc;
            d_rs_val <= rs_fwd;
            d_rd_val <= rd_fwd;
        end
    end

    // Commit trace mirrors the register write port
    assign trace_wen_o  = rf_wen;
    assign trace_addr_o = rf_w_addr;
    assign trace_data_o = rf_w_data;

endmodule

//--- logic/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    // Instruction opcodes
    typedef enum logic [5:0] {
        NOP   = 6'h00,
        ADD   = 6'h01,
        SUB   = 6'h02,
        AND   = 6'h03,
        OR    = 6'h04,
        XOR   = 6'h05,
        MOV   = 6'h06,
        BEQZ  = 6'h07,
        BNEQZ = 6'h08,
        JALR  = 6'h09,
        DONE  = 6'h0a
    } opcode_e;

    // 16-bit instruction word
    // rs_imm is a source register or, for branches, a signed PC offset
    typedef struct packed {
        opcode_e                 op;
        logic [`CORE_RF_AW-1:0]  rd;
        logic [`CORE_RF_AW-1:0]  rs_imm;
    } instr_t;

    // Network packet operations
    typedef enum logic [1:0] {
        NET_NONE  = 2'd0,
        NET_INSTR = 2'd1,
        NET_REG   = 2'd2,
        NET_PC    = 2'd3
    } net_op_e;

    // Core run states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        ERR  = 2'd2
    } core_state_e;

endpackage

//--- logic/fetch_unit.sv
`include "core_cfg.svh"

module fetch_unit
    import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        n_reset,
    net_cmd_if.sink                     cmd,
    input  logic                        stall_i,
    input  logic                        flush_i,
    input  logic                        redirect_i,
    input  logic [`CORE_IMEM_AW-1:0]    target_i,
    output instr_t                      instr_o,
    output logic [`CORE_IMEM_AW-1:0]    pc_o
);

    // Instruction memory, written only from the network
    instr_t                     imem [0:(1<<`CORE_IMEM_AW)-1];
    instr_t                     imem_q;

    logic [`CORE_IMEM_AW-1:0]   pc_r;
    logic [`CORE_IMEM_AW-1:0]   pc_n;
    logic [`CORE_IMEM_AW-1:0]   imem_addr;

    // Memory output was taken over by a network write last cycle
    logic                       stale_r;

    // Next PC, network first, then redirect, then hold or step
    always_comb
    begin
        if (cmd.pc_wr)
            pc_n = cmd.addr;
        else if (redirect_i)
            pc_n = target_i;
        // Hold on a stale read so the memory re-reads the current PC
        else if (stall_i || stale_r)
            pc_n = pc_r;
        else
            pc_n = pc_r + 1'b1;
    end

    // Network writes borrow the memory port
    assign imem_addr = cmd.imem_wr ? cmd.addr : pc_n;

    // Synchronous read, imem_q lines up with pc_r
    always_ff @(posedge clk)
    begin
        if (cmd.imem_wr)
            imem[imem_addr] <= cmd.data[$bits(instr_t)-1:0];
        imem_q <= imem[imem_addr];
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            pc_r    <= '0;
            stale_r <= 1'b0;
        end
        else
        begin
            pc_r    <= pc_n;
            stale_r <= cmd.imem_wr;
        end
    end

    // Fetch register
    // Bubble on flush, stale read, or once DONE has been fetched
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            instr_o <= '0;
        else if (!stall_i)
        begin
            if (flush_i || stale_r || (instr_o.op == DONE))
                instr_o <= '0;
            else
                instr_o <= imem_q;
        end
    end

    // PC of the fetched instruction
    always_ff @(posedge clk)
    begin
        if (!stall_i)
            pc_o <= pc_r;
    end

endmodule

//--- logic/net_cmd_if.sv
`include "core_cfg.svh"

// Decoded network commands, already matched against this core's ID
interface net_cmd_if;

    // Single-cycle strobes
    logic                       imem_wr;
    logic                       reg_wr;
    logic                       pc_wr;

    // Packet payload, shared by all three commands
    logic [`CORE_IMEM_AW-1:0]   addr;
    logic [`CORE_DATA_W-1:0]    data;

    // Driven by the network controller
    modport ctrl (output imem_wr, reg_wr, pc_wr, addr, data);

    // Fetch unit and datapath
    modport sink (input imem_wr, reg_wr, pc_wr, addr, data);

endinterface

//--- logic/net_ctrl.sv
`include "core_cfg.svh"

module net_ctrl
    import core_pkg::*;
(
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic [`CORE_NET_ID_W-1:0]   net_id_i,
    input  net_op_e                     net_op_i,
    input  logic [`CORE_IMEM_AW-1:0]    net_addr_i,
    input  logic [`CORE_DATA_W-1:0]     net_data_i,
    input  logic                        done_commit_i,
    net_cmd_if.ctrl                     cmd,
    output core_state_e                 state_o,
    output logic                        exception_o
);

    logic           id_match;
    logic           pc_cmd;
    logic           pc_wr_idle;
    core_state_e    state_n;
    logic           exception_n;

    // Packet is for this core
    assign id_match = (net_id_i == `CORE_NET_ID);

    // Raw PC command, legal or not
    assign pc_cmd = id_match && (net_op_i == NET_PC);

    // PC may only be loaded from IDLE
    assign pc_wr_idle = pc_cmd && (state_o == IDLE);

    assign cmd.imem_wr = id_match && (net_op_i == NET_INSTR);
    assign cmd.reg_wr  = id_match && (net_op_i == NET_REG);
    assign cmd.pc_wr   = pc_wr_idle;
    assign cmd.addr    = net_addr_i;
    assign cmd.data    = net_data_i;

    // Next state
    always_comb
    begin
        state_n = state_o;
        case (state_o)
            IDLE:
            begin
                if (pc_wr_idle)
                    state_n = RUN;
            end
            RUN:
            begin
                // A stray PC write wins over a DONE in the same cycle
                if (pc_cmd)
                    state_n = ERR;
                else if (done_commit_i)
                    state_n = IDLE;
            end
            // ERR is left only through reset
            default: state_n = ERR;
        endcase
    end

    // Sticky once set
    assign exception_n = exception_o || (pc_cmd && (state_o != IDLE));

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_o     <= IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            state_o     <= state_n;
            exception_o <= exception_n;
        end
    end

endmodule

//--- logic/reg_file.sv
`include "core_cfg.svh"

module reg_file (
    input  logic                        clk,
    input  logic [`CORE_RF_AW-1:0]      rs_addr_i,
    input  logic [`CORE_RF_AW-1:0]      rd_addr_i,
    input  logic [`CORE_RF_AW-1:0]      w_addr_i,
    input  logic                        wen_i,
    input  logic [`CORE_DATA_W-1:0]     w_data_i,
    output logic [`CORE_DATA_W-1:0]     rs_val_o,
    output logic [`CORE_DATA_W-1:0]     rd_val_o
);

    logic [`CORE_DATA_W-1:0] regs [0:(1<<`CORE_RF_AW)-1];

    // Register zero is never written
    always_ff @(posedge clk)
    begin
        if (wen_i && (w_addr_i != '0))
            regs[w_addr_i] <= w_data_i;
    end

    // Asynchronous reads, zero is hardwired
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

//--- sources.f
+incdir+include
logic/core_pkg.sv
logic/net_cmd_if.sv
logic/net_ctrl.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/core.sv
dv/core_tb.sv
